// File: common/enid_pkg.sv
// ##############################
// enid link definitions
// ##############################

`default_nettype none

package enid_pkg;

    // Link and transaction widths
    localparam int ENID_LINK_W      = 32;
    localparam int ENID_MODULE_ID_W = 4;
    localparam int ENID_SUB_ID_W    = 4;
    localparam int ENID_ADDR_W      = 16;
    localparam int ENID_LEN_W       = 4;
    localparam int ENID_VC_W        = 2;
    localparam int ENID_CR_W        = 4;
    localparam int ENID_CRC_W       = 8;

    // Credit limits
    localparam int ENID_INIT_CREDITS = 8;
    localparam int ENID_MAX_CREDITS  = 15;

    // Largest packet payload in flits
    localparam int ENID_MAX_BEATS = 15;

    // Zero fill below the response header fields
    localparam int ENID_RSP_PAD_W = ENID_LINK_W - 4 - ENID_LEN_W;

    typedef logic [ENID_LINK_W-1:0]      flit_t;
    typedef logic [ENID_ADDR_W-1:0]      addr_t;
    typedef logic [ENID_LEN_W-1:0]       len_t;
    typedef logic [ENID_MODULE_ID_W-1:0] mod_id_t;
    typedef logic [ENID_SUB_ID_W-1:0]    sub_id_t;
    typedef logic [ENID_VC_W-1:0]        vc_t;
    typedef logic [ENID_CR_W-1:0]        credit_t;
    typedef logic [ENID_CRC_W-1:0]       crc_t;

    typedef enum logic [1:0] {
        MEM = 2'd0,
        MSG = 2'd1,
        RSP = 2'd2
    } pkt_type_e;

    typedef enum logic [1:0] {
        RD = 2'd0,
        WR = 2'd1
    } mem_op_e;

    typedef enum logic [1:0] {
        OK    = 2'd0,
        ERR   = 2'd1,
        RETRY = 2'd2
    } rsp_status_e;

    // Request header flit, MSB first
    typedef struct packed {
        pkt_type_e pkt_type;
        mem_op_e   mem_op;
        mod_id_t   dest_mod;
        sub_id_t   dest_sub;
        len_t      len;
        addr_t     addr;
    } req_hdr_t;

    // Response header flit, MSB first
    typedef struct packed {
        pkt_type_e                 pkt_type;
        rsp_status_e               status;
        len_t                      len;
        logic [ENID_RSP_PAD_W-1:0] rsvd;
    } rsp_hdr_t;

    // CRC-8, poly 0x07, one flit folded in MSB first
    function automatic crc_t enid_crc8(input crc_t crc_in, input flit_t flit);
        crc_t c;
        logic fb;
        c = crc_in;
        for (int i = ENID_LINK_W - 1; i >= 0; i--) begin
            fb = c[ENID_CRC_W-1] ^ flit[i];
            c  = {c[ENID_CRC_W-2:0], 1'b0};
            if (fb) begin
                c = c ^ crc_t'(8'h07);
            end
        end
        return c;
    endfunction

endpackage

`default_nettype wire

// File: endpoint/enid_credit_tracker.sv
// ##############################
// enid TX credit tracker
// ##############################

`timescale 1ns/1ps
`default_nettype none

module enid_credit_tracker import enid_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  credit_t ltx_credit,
    input  logic    flit_sent,
    output logic    has_credit
);

    credit_t              count;
    logic [ENID_CR_W:0]   cnt_sum;

    // One extra bit keeps the sum of returned credits from wrapping
    assign cnt_sum = {1'b0, count} + {1'b0, ltx_credit} -
                     {{ENID_CR_W{1'b0}}, flit_sent};

    assign has_credit = (count != '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count <= credit_t'(ENID_INIT_CREDITS);
        end else if (cnt_sum > ENID_MAX_CREDITS) begin
            count <= credit_t'(ENID_MAX_CREDITS);
        end else begin
            count <= cnt_sum[ENID_CR_W-1:0];
        end
    end

    // Packetizer may only send while a credit is left
    a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
        flit_sent |-> count != '0);

endmodule

`default_nettype wire

// File: endpoint/enid_tx_packetizer.sv
// ##############################
// enid TX packetizer
// ##############################

`timescale 1ns/1ps
`default_nettype none

module enid_tx_packetizer import enid_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,

    input  logic      req_valid,
    output logic      req_ready,
    input  pkt_type_e req_type,
    input  mem_op_e   req_mem_op,
    input  mod_id_t   req_dest_mod,
    input  sub_id_t   req_dest_sub,
    input  addr_t     req_addr,
    input  len_t      req_len,

    input  logic      req_wvalid,
    output logic      req_wready,
    input  flit_t     req_wdata,
    input  logic      req_wlast,

    output logic      ltx_valid,
    input  logic      ltx_ready,
    output flit_t     ltx_flit,
    output logic      ltx_sof,
    output logic      ltx_eof,
    output vc_t       ltx_vc,

    input  logic      has_credit,
    output logic      flit_sent,
    input  logic      rsp_done
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_HDR,
        S_DATA,
        S_CRC,
        S_WAIT
    } tx_state_e;

    tx_state_e state;
    req_hdr_t  hdr_q;
    crc_t      crc_q;
    len_t      beat_cnt;
    len_t      beat_nxt;
    logic      has_data;
    logic      xfer;

    // WR and MSG carry a payload, RD does not
    assign has_data = (hdr_q.pkt_type == MSG) ||
                      (hdr_q.pkt_type == MEM && hdr_q.mem_op == WR);
    assign beat_nxt = beat_cnt + len_t'(1);

    assign req_ready  = (state == S_IDLE);
    assign req_wready = (state == S_DATA) && has_credit && ltx_ready;

    always_comb begin
        ltx_valid = 1'b0;
        ltx_flit  = '0;
        case (state)
            S_HDR: begin
                ltx_valid = has_credit;
                ltx_flit  = flit_t'(hdr_q);
            end
            S_DATA: begin
                // Write beats go straight onto the link
                ltx_valid = has_credit && req_wvalid;
                ltx_flit  = req_wdata;
            end
            S_CRC: begin
                ltx_valid = has_credit;
                ltx_flit  = {{(ENID_LINK_W-ENID_CRC_W){1'b0}}, crc_q};
            end
            default: begin
                ltx_valid = 1'b0;
            end
        endcase
    end

    assign ltx_sof   = (state == S_HDR);
    assign ltx_eof   = (state == S_CRC);
    assign ltx_vc    = (hdr_q.pkt_type == MSG) ? vc_t'(1) : vc_t'(0);
    assign xfer      = ltx_valid && ltx_ready;
    assign flit_sent = xfer;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= S_IDLE;
            beat_cnt <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (req_valid) begin
                        state    <= S_HDR;
                        beat_cnt <= '0;
                    end
                end
                S_HDR: begin
                    if (xfer) begin
                        state <= (has_data && hdr_q.len != '0) ? S_DATA : S_CRC;
                    end
                end
                S_DATA: begin
                    if (xfer) begin
                        beat_cnt <= beat_nxt;
                        if (beat_nxt == hdr_q.len) begin
                            state <= S_CRC;
                        end
                    end
                end
                S_CRC: begin
                    if (xfer) begin
                        state <= S_WAIT;
                    end
                end
                S_WAIT: begin
                    // Hold off the next request until the response is out
                    if (rsp_done) begin
                        state <= S_IDLE;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // Header latch and running CRC over every flit sent
    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            hdr_q <= '{pkt_type: req_type, mem_op: req_mem_op, dest_mod: req_dest_mod,
                       dest_sub: req_dest_sub, len: req_len, addr: req_addr};
            crc_q <= '0;
        end else if (xfer) begin
            crc_q <= enid_crc8(crc_q, ltx_flit);
        end
    end

    // The last write beat must line up with the header length
    a_wlast_on_len: assert property (@(posedge clk) disable iff (!rst_n)
        req_wvalid && req_wready |-> req_wlast == (beat_nxt == hdr_q.len));

    // A header or trailer held back by the link keeps its credit and its value
    a_flit_held: assert property (@(posedge clk) disable iff (!rst_n)
        ltx_valid && !ltx_ready && state != S_DATA |=> ltx_valid && $stable(ltx_flit));

endmodule

`default_nettype wire

// File: endpoint/enid_rx_depacketizer.sv
// ##############################
// enid RX depacketizer
// ##############################

`timescale 1ns/1ps
`default_nettype none

module enid_rx_depacketizer import enid_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,

    input  logic        lrx_valid,
    output logic        lrx_ready,
    input  flit_t       lrx_flit,
    input  logic        lrx_sof,
    input  logic        lrx_eof,
    input  vc_t         lrx_vc,

    output logic        rsp_valid,
    input  logic        rsp_ready,
    output rsp_status_e rsp_status,
    output len_t        rsp_len,

    output logic        rsp_rvalid,
    input  logic        rsp_rready,
    output flit_t       rsp_rdata,
    output logic        rsp_rlast,

    output logic        rsp_done
);

    typedef enum logic [2:0] {
        S_HDR,
        S_DATA,
        S_CRC,
        S_RSP,
        S_RDATA
    } rx_state_e;

    rx_state_e   state;
    rsp_hdr_t    hdr_q;
    rsp_hdr_t    rx_hdr;
    vc_t         vc_q;
    flit_t       data_buf [ENID_MAX_BEATS];
    crc_t        crc_q;
    len_t        cnt;
    len_t        cnt_nxt;
    rsp_status_e status_q;
    len_t        len_q;
    logic        rx_en;
    logic        rx_xfer;

    assign rx_hdr    = rsp_hdr_t'(lrx_flit);
    assign cnt_nxt   = cnt + len_t'(1);

    // Accept flits only while a packet is being collected
    assign lrx_ready = rx_en && (state == S_HDR || state == S_DATA || state == S_CRC);
    assign rx_xfer   = lrx_valid && lrx_ready;

    assign rsp_valid  = (state == S_RSP);
    assign rsp_status = status_q;
    assign rsp_len    = len_q;
    assign rsp_rvalid = (state == S_RDATA);
    assign rsp_rdata  = data_buf[cnt];
    assign rsp_rlast  = rsp_rvalid && (cnt_nxt == len_q);

    assign rsp_done = (rsp_valid && rsp_ready && len_q == '0) ||
                      (rsp_rvalid && rsp_rready && rsp_rlast);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= S_HDR;
            cnt   <= '0;
            rx_en <= 1'b0;
        end else begin
            rx_en <= 1'b1;
            case (state)
                S_HDR: begin
                    if (rx_xfer) begin
                        cnt   <= '0;
                        state <= (rx_hdr.len == '0) ? S_CRC : S_DATA;
                    end
                end
                S_DATA: begin
                    if (rx_xfer) begin
                        cnt <= cnt_nxt;
                        if (cnt_nxt == hdr_q.len) begin
                            state <= S_CRC;
                        end
                    end
                end
                S_CRC: begin
                    if (rx_xfer) begin
                        state <= S_RSP;
                    end
                end
                S_RSP: begin
                    if (rsp_ready) begin
                        cnt   <= '0;
                        state <= (len_q == '0) ? S_HDR : S_RDATA;
                    end
                end
                S_RDATA: begin
                    if (rsp_rready) begin
                        cnt <= cnt_nxt;
                        if (rsp_rlast) begin
                            state <= S_HDR;
                        end
                    end
                end
                default: begin
                    state <= S_HDR;
                end
            endcase
        end
    end

    // Header, payload buffer and CRC check
    always_ff @(posedge clk) begin
        if (rx_xfer) begin
            case (state)
                S_HDR: begin
                    hdr_q <= rx_hdr;
                    vc_q  <= lrx_vc;
                    crc_q <= enid_crc8('0, lrx_flit);
                end
                S_DATA: begin
                    data_buf[cnt] <= lrx_flit;
                    crc_q         <= enid_crc8(crc_q, lrx_flit);
                end
                default: begin
                    // Bad trailer turns into ERR with no data
                    if (lrx_flit[ENID_CRC_W-1:0] == crc_q) begin
                        status_q <= hdr_q.status;
                        len_q    <= hdr_q.len;
                    end else begin
                        status_q <= ERR;
                        len_q    <= '0;
                    end
                end
            endcase
        end
    end

    // Framing must follow the FSM: sof on the header, eof on the trailer
    a_sof_eof_framing: assert property (@(posedge clk) disable iff (!rst_n)
        rx_xfer |-> (lrx_sof == (state == S_HDR)) && (lrx_eof == (state == S_CRC)));

    a_vc_stable_in_pkt: assert property (@(posedge clk) disable iff (!rst_n)
        rx_xfer && state != S_HDR |-> lrx_vc == vc_q);

endmodule

`default_nettype wire

// File: endpoint/enid_endpoint.sv
// ##############################
// enid link endpoint
// ##############################

`timescale 1ns/1ps
`default_nettype none

module enid_endpoint import enid_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,

    // Local request
    input  logic        req_valid,
    output logic        req_ready,
    input  pkt_type_e   req_type,
    input  mem_op_e     req_mem_op,
    input  mod_id_t     req_dest_mod,
    input  sub_id_t     req_dest_sub,
    input  addr_t       req_addr,
    input  len_t        req_len,

    // Write data for WR and MSG
    input  logic        req_wvalid,
    output logic        req_wready,
    input  flit_t       req_wdata,
    input  logic        req_wlast,

    // Local response
    output logic        rsp_valid,
    input  logic        rsp_ready,
    output rsp_status_e rsp_status,
    output len_t        rsp_len,

    // Read data for RD and MSG
    output logic        rsp_rvalid,
    input  logic        rsp_rready,
    output flit_t       rsp_rdata,
    output logic        rsp_rlast,

    // Link TX
    output logic        ltx_valid,
    input  logic        ltx_ready,
    output flit_t       ltx_flit,
    output logic        ltx_sof,
    output logic        ltx_eof,
    output vc_t         ltx_vc,
    input  credit_t     ltx_credit,

    // Link RX
    input  logic        lrx_valid,
    output logic        lrx_ready,
    input  flit_t       lrx_flit,
    input  logic        lrx_sof,
    input  logic        lrx_eof,
    input  vc_t         lrx_vc
);

    logic has_credit;
    logic flit_sent;
    logic rsp_done;

    enid_tx_packetizer i_tx (
        .clk          (clk),
        .rst_n        (rst_n),
        .req_valid    (req_valid),
        .req_ready    (req_ready),
        .req_type     (req_type),
        .req_mem_op   (req_mem_op),
        .req_dest_mod (req_dest_mod),
        .req_dest_sub (req_dest_sub),
        .req_addr     (req_addr),
        .req_len      (req_len),
        .req_wvalid   (req_wvalid),
        .req_wready   (req_wready),
        .req_wdata    (req_wdata),
        .req_wlast    (req_wlast),
        .ltx_valid    (ltx_valid),
        .ltx_ready    (ltx_ready),
        .ltx_flit     (ltx_flit),
        .ltx_sof      (ltx_sof),
        .ltx_eof      (ltx_eof),
        .ltx_vc       (ltx_vc),
        .has_credit   (has_credit),
        .flit_sent    (flit_sent),
        .rsp_done     (rsp_done)
    );

    enid_rx_depacketizer i_rx (
        .clk        (clk),
        .rst_n      (rst_n),
        .lrx_valid  (lrx_valid),
        .lrx_ready  (lrx_ready),
        .lrx_flit   (lrx_flit),
        .lrx_sof    (lrx_sof),
        .lrx_eof    (lrx_eof),
        .lrx_vc     (lrx_vc),
        .rsp_valid  (rsp_valid),
        .rsp_ready  (rsp_ready),
        .rsp_status (rsp_status),
        .rsp_len    (rsp_len),
        .rsp_rvalid (rsp_rvalid),
        .rsp_rready (rsp_rready),
        .rsp_rdata  (rsp_rdata),
        .rsp_rlast  (rsp_rlast),
        .rsp_done   (rsp_done)
    );

    enid_credit_tracker i_credit (
        .clk        (clk),
        .rst_n      (rst_n),
        .ltx_credit (ltx_credit),
        .flit_sent  (flit_sent),
        .has_credit (has_credit)
    );

endmodule

`default_nettype wire

// File: sim/enid_link_peer.sv
// ##############################
// enid link far-end model
// ##############################

`timescale 1ns/1ps
`default_nettype none

module enid_link_peer import enid_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,

    // Request packets from the endpoint
    input  logic    ltx_valid,
    output logic    ltx_ready,
    input  flit_t   ltx_flit,
    input  logic    ltx_sof,
    input  logic    ltx_eof,
    input  vc_t     ltx_vc,
    output credit_t ltx_credit,

    // Response packets to the endpoint
    output logic    lrx_valid,
    input  logic    lrx_ready,
    output flit_t   lrx_flit,
    output logic    lrx_sof,
    output logic    lrx_eof,
    output vc_t     lrx_vc,

    // Test controls
    input  logic    credit_hold,
    input  logic    corrupt_next,
    input  logic    retry_next,
    output logic    bad_req
);

    localparam mod_id_t PEER_ID = mod_id_t'(3);

    flit_t      mem [65536];
    flit_t      rx_q [$];
    flit_t      tx_q [$];
    logic [3:0] ret_pipe;
    int         pending;
    int         tx_idx;
    logic       req_err;

    assign lrx_vc = '0;

    initial begin
        ltx_ready  = 1'b0;
        ltx_credit = '0;
        lrx_valid  = 1'b0;
        lrx_flit   = '0;
        lrx_sof    = 1'b0;
        lrx_eof    = 1'b0;
        bad_req    = 1'b0;
        for (int i = 0; i < 65536; i++) begin
            mem[i] = {16'(i) ^ 16'hc3a5, 16'(i)};
        end
    end

    // Byte-wise CRC-8 with poly 0x07, high byte first
    function automatic crc_t crc_bytes(input crc_t crc_in, input flit_t flit);
        crc_t c;
        c = crc_in;
        for (int b = 3; b >= 0; b--) begin
            c = c ^ flit[b*8 +: 8];
            for (int k = 0; k < 8; k++) begin
                c = c[7] ? ((c << 1) ^ crc_t'(8'h07)) : (c << 1);
            end
        end
        return c;
    endfunction

    // Answers the request held in rx_q and puts the response packet in tx_q
    task automatic build_response(output logic err);
        req_hdr_t    h;
        rsp_hdr_t    r;
        rsp_status_e rsp_st;
        len_t        rlen;
        int          n_data;
        crc_t        crc;
        flit_t       trailer;
        h       = req_hdr_t'(rx_q[0]);
        trailer = rx_q[$];
        n_data  = rx_q.size() - 2;
        crc     = '0;
        for (int i = 0; i < rx_q.size() - 1; i++) begin
            crc = crc_bytes(crc, rx_q[i]);
        end
        err = (crc != trailer[ENID_CRC_W-1:0]);
        if (h.pkt_type == MSG || (h.pkt_type == MEM && h.mem_op == WR)) begin
            err = err || (n_data != int'(h.len));
        end else begin
            err = err || (n_data != 0);
        end

        rsp_st = OK;
        rlen   = '0;
        if (h.dest_mod != PEER_ID) begin
            rsp_st = ERR;
        end else if (retry_next) begin
            rsp_st = RETRY;
        end else if (h.pkt_type == MSG || h.mem_op == RD) begin
            rlen = h.len;
        end

        r = '{pkt_type: RSP, status: rsp_st, len: rlen, rsvd: '0};
        tx_q.delete();
        tx_q.push_back(flit_t'(r));
        for (int i = 0; i < int'(rlen); i++) begin
            if (h.pkt_type == MSG) begin
                tx_q.push_back(rx_q[1+i]);
            end else begin
                tx_q.push_back(mem[h.addr + addr_t'(i)]);
            end
        end
        if (rsp_st == OK && h.pkt_type == MEM && h.mem_op == WR) begin
            for (int i = 0; i < n_data; i++) begin
                mem[h.addr + addr_t'(i)] = rx_q[1+i];
            end
        end

        crc = '0;
        foreach (tx_q[i]) begin
            crc = crc_bytes(crc, tx_q[i]);
        end
        // One flipped bit is enough for the receiver to reject the packet
        if (corrupt_next) begin
            crc = crc ^ crc_t'(8'h01);
        end
        tx_q.push_back({{(ENID_LINK_W-ENID_CRC_W){1'b0}}, crc});
    endtask

    always @(posedge clk) begin
        bad_req <= 1'b0;
        if (!rst_n) begin
            ltx_ready  <= 1'b1;
            ltx_credit <= '0;
            lrx_valid  <= 1'b0;
            lrx_sof    <= 1'b0;
            lrx_eof    <= 1'b0;
            ret_pipe   <= '0;
            pending = 0;
            rx_q.delete();
            tx_q.delete();
        end else begin
            // Each accepted flit comes back as a credit four cycles later
            ret_pipe <= {ret_pipe[2:0], ltx_valid && ltx_ready};
            if (credit_hold) begin
                ltx_credit <= '0;
                pending = pending + int'(ret_pipe[3]);
            end else begin
                ltx_credit <= credit_t'(pending + int'(ret_pipe[3]));
                pending = 0;
            end

            if (ltx_valid && ltx_ready) begin
                if (ltx_sof != (rx_q.size() == 0)) begin
                    bad_req <= 1'b1;
                end
                rx_q.push_back(ltx_flit);
                if (ltx_eof) begin
                    build_response(req_err);
                    if (req_err) begin
                        bad_req <= 1'b1;
                    end
                    rx_q.delete();
                    tx_idx = 0;
                    ltx_ready <= 1'b0;
                    lrx_valid <= 1'b1;
                    lrx_flit  <= tx_q[0];
                    lrx_sof   <= 1'b1;
                    lrx_eof   <= 1'b0;
                end
            end else if (lrx_valid && lrx_ready) begin
                tx_idx = tx_idx + 1;
                if (tx_idx == tx_q.size()) begin
                    lrx_valid <= 1'b0;
                    lrx_sof   <= 1'b0;
                    lrx_eof   <= 1'b0;
                    ltx_ready <= 1'b1;
                end else begin
                    lrx_flit <= tx_q[tx_idx];
                    lrx_sof  <= 1'b0;
                    lrx_eof  <= (tx_idx == tx_q.size() - 1);
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: sim/tb_enid_endpoint.sv
// ##############################
// enid endpoint testbench
// ##############################

`timescale 1ns/1ps
`default_nettype none

module tb_enid_endpoint import enid_pkg::*; ();

    localparam int          CLK_PERIOD      = 100;
    localparam int          N_TXN           = 40;
    localparam int          WATCHDOG_CYCLES = N_TXN * 200;
    localparam logic [31:0] SEED            = 32'h68c191b9;
    localparam mod_id_t     PEER_ID         = mod_id_t'(3);

    logic        clk;
    logic        rst_n;
    logic        req_valid;
    logic        req_ready;
    pkt_type_e   req_type;
    mem_op_e     req_mem_op;
    mod_id_t     req_dest_mod;
    sub_id_t     req_dest_sub;
    addr_t       req_addr;
    len_t        req_len;
    logic        req_wvalid;
    logic        req_wready;
    flit_t       req_wdata;
    logic        req_wlast;
    logic        rsp_valid;
    logic        rsp_ready = 1'b1;
    rsp_status_e rsp_status;
    len_t        rsp_len;
    logic        rsp_rvalid;
    logic        rsp_rready = 1'b1;
    flit_t       rsp_rdata;
    logic        rsp_rlast;
    logic        ltx_valid;
    logic        ltx_ready;
    flit_t       ltx_flit;
    logic        ltx_sof;
    logic        ltx_eof;
    vc_t         ltx_vc;
    credit_t     ltx_credit;
    logic        lrx_valid;
    logic        lrx_ready;
    flit_t       lrx_flit;
    logic        lrx_sof;
    logic        lrx_eof;
    vc_t         lrx_vc;
    logic        credit_hold;
    logic        corrupt_next;
    logic        retry_next;
    logic        bad_req;
    logic        bp_en;

    // Mirror of the peer memory and the expected response
    flit_t       shadow [65536];
    flit_t       wbuf [ENID_MAX_BEATS];
    flit_t       exp_data [ENID_MAX_BEATS];
    rsp_status_e exp_status;
    len_t        exp_len;
    vc_t         exp_vc;
    int          beat_idx;
    int          outstanding;
    int          errors;
    int          n_txn;
    addr_t       addr;
    len_t        len;

    enid_endpoint i_dut (.*);

    enid_link_peer i_peer (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Random stalls on the local response side
    always @(posedge clk) begin
        if (bp_en) begin
            rsp_ready  <= 1'($urandom_range(1));
            rsp_rready <= 1'($urandom_range(1));
        end else begin
            rsp_ready  <= 1'b1;
            rsp_rready <= 1'b1;
        end
    end

    // Flits in flight on the link and the rdata beat number
    always @(posedge clk) begin
        if (!rst_n) begin
            outstanding <= 0;
            beat_idx    <= 0;
        end else begin
            outstanding <= outstanding + int'(ltx_valid && ltx_ready) - int'(ltx_credit);
            if (rsp_valid && rsp_ready) begin
                beat_idx <= 0;
            end else if (rsp_rvalid && rsp_rready) begin
                beat_idx <= beat_idx + 1;
            end
        end
    end

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        errors = errors + 1;
        $display("** Error: %s = %h, expected %h at %0t", name, got, exp, $time);
    endtask

    task automatic report_failure(input string what);
        errors = errors + 1;
        $display("Failure at %0t: %s", $time, what);
    endtask

    a_reset_idle: assert property (@(posedge clk) $rose(rst_n) |->
        !ltx_valid && !rsp_valid && !rsp_rvalid && !lrx_ready && req_ready)
        else report_failure("outputs not idle after reset");

    a_rsp_status: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_valid && rsp_ready |-> rsp_status == exp_status)
        else report_mismatch("rsp_status", 32'($sampled(rsp_status)), 32'($sampled(exp_status)));

    a_rsp_len: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_valid && rsp_ready |-> rsp_len == exp_len)
        else report_mismatch("rsp_len", 32'($sampled(rsp_len)), 32'($sampled(exp_len)));

    a_rdata_expected: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_rvalid |-> beat_idx < int'(exp_len))
        else report_failure("rdata beat beyond the response length");

    a_rdata: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_rvalid && rsp_rready |-> rsp_rdata == exp_data[beat_idx])
        else report_mismatch("rsp_rdata", $sampled(rsp_rdata), $sampled(exp_data[beat_idx]));

    a_rlast: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_rvalid |-> rsp_rlast == (beat_idx == int'(exp_len) - 1))
        else report_mismatch("rsp_rlast", 32'($sampled(rsp_rlast)),
                             32'($sampled(beat_idx) == int'($sampled(exp_len)) - 1));

    a_rsp_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_status) && $stable(rsp_len))
        else report_failure("response changed while stalled");

    a_rdata_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_rvalid && !rsp_rready |=> rsp_rvalid && $stable(rsp_rdata) && $stable(rsp_rlast))
        else report_failure("read data changed while stalled");

    a_ltx_vc: assert property (@(posedge clk) disable iff (!rst_n)
        ltx_valid |-> ltx_vc == exp_vc)
        else report_mismatch("ltx_vc", 32'($sampled(ltx_vc)), 32'($sampled(exp_vc)));

    a_credit_limit: assert property (@(posedge clk) disable iff (!rst_n)
        outstanding <= ENID_INIT_CREDITS)
        else report_mismatch("flits in flight", $sampled(outstanding), ENID_INIT_CREDITS);

    a_req_packet: assert property (@(posedge clk) disable iff (!rst_n) !bad_req)
        else report_failure("peer received a malformed request packet");

    task automatic fill_wbuf();
        for (int i = 0; i < ENID_MAX_BEATS; i++) begin
            wbuf[i] = $urandom();
        end
    endtask

    // One request with its write data, then wait for the full response
    task automatic run_txn(input pkt_type_e t, input mem_op_e op, input mod_id_t dm,
                           input addr_t a, input len_t n);
        logic has_data;
        logic peer_ok;
        has_data = (t == MSG) || (t == MEM && op == WR);
        @(posedge clk);
        peer_ok = (dm == PEER_ID) && !retry_next;
        exp_vc  = (t == MSG) ? vc_t'(1) : vc_t'(0);
        if (dm != PEER_ID) begin
            exp_status = ERR;
        end else if (retry_next) begin
            exp_status = RETRY;
        end else if (corrupt_next) begin
            exp_status = ERR;
        end else begin
            exp_status = OK;
        end
        exp_len = (exp_status == OK && (t == MSG || op == RD)) ? n : '0;
        for (int i = 0; i < int'(exp_len); i++) begin
            exp_data[i] = (t == MSG) ? wbuf[i] : shadow[a + addr_t'(i)];
        end
        if (peer_ok && t == MEM && op == WR) begin
            for (int i = 0; i < int'(n); i++) begin
                shadow[a + addr_t'(i)] = wbuf[i];
            end
        end

        req_valid    <= 1'b1;
        req_type     <= t;
        req_mem_op   <= op;
        req_dest_mod <= dm;
        req_dest_sub <= sub_id_t'($urandom());
        req_addr     <= a;
        req_len      <= n;
        do @(posedge clk); while (!req_ready);
        req_valid <= 1'b0;

        if (has_data) begin
            for (int i = 0; i < int'(n); i++) begin
                req_wvalid <= 1'b1;
                req_wdata  <= wbuf[i];
                req_wlast  <= (i == int'(n) - 1);
                do @(posedge clk); while (!req_wready);
            end
            req_wvalid <= 1'b0;
            req_wlast  <= 1'b0;
        end

        do @(posedge clk); while (!(rsp_valid && rsp_ready));
        if (rsp_len != '0) begin
            do @(posedge clk); while (!(rsp_rvalid && rsp_rready && rsp_rlast));
        end
        n_txn = n_txn + 1;
    endtask

    task automatic run_random_txn();
        int kind;
        kind = $urandom_range(2);
        addr = addr_t'($urandom());
        len  = len_t'($urandom_range(ENID_MAX_BEATS, 1));
        fill_wbuf();
        case (kind)
            0:       run_txn(MEM, WR, PEER_ID, addr, len);
            1:       run_txn(MEM, RD, PEER_ID, addr, len);
            default: run_txn(MSG, RD, PEER_ID, addr, len);
        endcase
    endtask

    initial begin
        void'($urandom(SEED));
        clk          = 1'b0;
        rst_n        = 1'b0;
        req_valid    = 1'b0;
        req_type     = MEM;
        req_mem_op   = RD;
        req_dest_mod = '0;
        req_dest_sub = '0;
        req_addr     = '0;
        req_len      = '0;
        req_wvalid   = 1'b0;
        req_wdata    = '0;
        req_wlast    = 1'b0;
        credit_hold  = 1'b0;
        corrupt_next = 1'b0;
        retry_next   = 1'b0;
        bp_en        = 1'b0;
        errors       = 0;
        n_txn        = 0;
        for (int i = 0; i < 65536; i++) begin
            shadow[i] = {16'(i) ^ 16'hc3a5, 16'(i)};
        end
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        // Write then read back the same words
        addr = addr_t'($urandom());
        len  = len_t'($urandom_range(ENID_MAX_BEATS, 1));
        fill_wbuf();
        run_txn(MEM, WR, PEER_ID, addr, len);
        run_txn(MEM, RD, PEER_ID, addr, len);

        // Message echo on VC 1
        fill_wbuf();
        run_txn(MSG, RD, PEER_ID, addr, len_t'($urandom_range(ENID_MAX_BEATS, 1)));

        // Unknown destination
        run_txn(MEM, RD, mod_id_t'(5), addr, len);

        // Bad trailer on the response
        corrupt_next <= 1'b1;
        run_txn(MEM, RD, PEER_ID, addr, len);
        corrupt_next <= 1'b0;

        // Longest write with the credit return held off for a while
        credit_hold <= 1'b1;
        fill_wbuf();
        fork
            run_txn(MEM, WR, PEER_ID, addr, len_t'(ENID_MAX_BEATS));
            begin
                repeat (40) @(posedge clk);
                credit_hold <= 1'b0;
            end
        join
        run_txn(MEM, RD, PEER_ID, addr, len_t'(ENID_MAX_BEATS));

        // Random traffic under response back-pressure, then a retry
        bp_en <= 1'b1;
        for (int k = 0; k < 16; k++) begin
            run_random_txn();
        end
        retry_next <= 1'b1;
        fill_wbuf();
        run_txn(MEM, WR, PEER_ID, addr, len);
        retry_next <= 1'b0;
        bp_en      <= 1'b0;

        repeat (5) @(posedge clk);
        $display("Summary: %0d transactions, %0d errors", n_txn, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the run did not complete within %0d cycles", WATCHDOG_CYCLES);
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
common/enid_pkg.sv
endpoint/enid_credit_tracker.sv
endpoint/enid_tx_packetizer.sv
endpoint/enid_rx_depacketizer.sv
endpoint/enid_endpoint.sv
sim/enid_link_peer.sv
sim/tb_enid_endpoint.sv

// File: Makefile
TOP := tb_enid_endpoint

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -Wno-fatal -f src.f --top-module $(TOP) -o sim_$(TOP)
	@out="$$(./obj_dir/sim_$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "No errors"

clean:
	rm -rf obj_dir
